// File: srAlu.sv
// ALU for add, sub, or, srl and sltu with zero flag
`timescale 1ns/1ps
`default_nettype none

module srAlu import srPkg::*; (
    input  logic [31:0] srcA_i,
    input  logic [31:0] srcB_i,
    input  aluOp_t      op_i,
    output logic [31:0] result_o,
    output logic        zero_o
);

    always_comb begin
        case (op_i)
            aluAdd:  result_o = srcA_i + srcB_i;
            aluSub:  result_o = srcA_i - srcB_i;
            aluOr:   result_o = srcA_i | srcB_i;
            // shift amount from low 5 bits only
            aluSrl:  result_o = srcA_i >> srcB_i[4:0];
            aluSltu: result_o = {31'b0, (srcA_i < srcB_i)};
            default: result_o = srcA_i + srcB_i;
        endcase
    end

    // beq/bne use this on the sub result
    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// File: srControl.sv
// instruction decoder and control signals,
// outstanding memory request tracking
`timescale 1ns/1ps
`default_nettype none

module srControl import srPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       runEn_i,
    input  instrWord_t instr_i,
    input  logic       aluZero_i,
    input  logic       reqReady_i,
    input  logic       respValid_i,
    output logic       pcWe_o,
    output logic       pcBranch_o,
    output logic       regWe_o,
    output srcBSel_t   srcBSel_o,
    output wdSel_t     wdSel_o,
    output aluOp_t     aluOp_o,
    output logic       reqValid_o,
    output logic       memWr_o
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       branch;
    logic       condZero;
    logic       writeReg;
    logic       memAccess;
    logic       outstanding;

    assign opcode = instr_i.rType.opcode;
    assign funct3 = instr_i.rType.funct3;
    assign funct7 = instr_i.rType.funct7;

    always_comb begin
        branch    = 1'b0;
        condZero  = 1'b0;
        writeReg  = 1'b0;
        memAccess = 1'b0;
        memWr_o   = 1'b0;
        srcBSel_o = srcBReg;
        wdSel_o   = wdAlu;
        aluOp_o   = aluAdd;

        case (opcode)
            opOp: begin
                writeReg = 1'b1;
                case ({funct7, funct3})
                    {f7Add, f3Add}:   aluOp_o = aluAdd;
                    {f7Sub, f3Sub}:   aluOp_o = aluSub;
                    {f7Or, f3Or}:     aluOp_o = aluOr;
                    {f7Srl, f3Srl}:   aluOp_o = aluSrl;
                    {f7Sltu, f3Sltu}: aluOp_o = aluSltu;
                    default:          writeReg = 1'b0;
                endcase
            end
            opImm: begin
                if (funct3 == f3Addi) begin
                    writeReg  = 1'b1;
                    srcBSel_o = srcBImmI;
                end
            end
            opLui: begin
                writeReg = 1'b1;
                wdSel_o  = wdImmU;
            end
            opLoad: begin
                if (funct3 == f3Lw) begin
                    writeReg  = 1'b1;
                    memAccess = 1'b1;
                    srcBSel_o = srcBImmI;
                    wdSel_o   = wdMem;
                end
            end
            opStore: begin
                if (funct3 == f3Sw) begin
                    memAccess = 1'b1;
                    memWr_o   = 1'b1;
                    srcBSel_o = srcBImmS;
                end
            end
            opBranch: begin
                aluOp_o = aluSub;
                if (funct3 == f3Beq) begin
                    branch   = 1'b1;
                    condZero = 1'b1;
                end else if (funct3 == f3Bne) begin
                    branch = 1'b1;
                end
            end
            default: begin
                // unknown opcode, falls through as a no-op
            end
        endcase
    end

    assign pcBranch_o = branch && (aluZero_i == condZero);

    // memory ops stall until the response arrives
    assign pcWe_o     = runEn_i && (!memAccess || respValid_i);
    assign regWe_o    = pcWe_o && writeReg;
    assign reqValid_o = runEn_i && memAccess && !outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (respValid_i) begin
            outstanding <= 1'b0;
        end else if (reqValid_o && reqReady_i) begin
            outstanding <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: srCpu.sv
// single-cycle core datapath: program counter, immediates,
// operand and write-back muxes, data memory request signals
`timescale 1ns/1ps
`default_nettype none

module srCpu import srPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        runEn_i,
    output logic [29:0] imAddr_o,
    input  instrWord_t  imData_i,
    input  logic [4:0]  dbgAddr_i,
    output logic [31:0] dbgData_o,
    srMemIf.cpu         mem
);
    logic [31:0] pc;
    logic [31:0] pcNext;
    logic        pcWe;
    logic        pcBranch;
    logic        regWe;
    srcBSel_t    srcBSel;
    wdSel_t      wdSel;
    aluOp_t      aluOp;
    logic        aluZero;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] dbgRegData;
    logic [31:0] srcB;
    logic [31:0] aluResult;
    logic [31:0] wdata;

    // immediates
    assign immI = {{20{imData_i.iType.imm12[11]}}, imData_i.iType.imm12};
    assign immS = {{20{imData_i.sbType.immHi[6]}}, imData_i.sbType.immHi, imData_i.sbType.immLo};
    assign immB = {{19{imData_i.sbType.immHi[6]}}, imData_i.sbType.immHi[6],
                   imData_i.sbType.immLo[0], imData_i.sbType.immHi[5:0],
                   imData_i.sbType.immLo[4:1], 1'b0};
    assign immU = {imData_i.iType.imm12, imData_i.iType.rs1, imData_i.iType.funct3, 12'b0};

    assign pcNext   = pcBranch ? (pc + immB) : (pc + 32'd4);
    assign imAddr_o = pc[31:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pcWe) begin
            pc <= pcNext;
        end
    end

    srControl control (
        .clk         (clk),
        .rst_n       (rst_n),
        .runEn_i     (runEn_i),
        .instr_i     (imData_i),
        .aluZero_i   (aluZero),
        .reqReady_i  (mem.reqReady),
        .respValid_i (mem.respValid),
        .pcWe_o      (pcWe),
        .pcBranch_o  (pcBranch),
        .regWe_o     (regWe),
        .srcBSel_o   (srcBSel),
        .wdSel_o     (wdSel),
        .aluOp_o     (aluOp),
        .reqValid_o  (mem.reqValid),
        .memWr_o     (mem.wr)
    );

    srRegFile regFile (
        .clk       (clk),
        .raddr1_i  (imData_i.rType.rs1),
        .raddr2_i  (imData_i.rType.rs2),
        .dbgAddr_i (dbgAddr_i),
        .waddr_i   (imData_i.rType.rd),
        .wdata_i   (wdata),
        .we_i      (regWe),
        .rdata1_o  (rs1Data),
        .rdata2_o  (rs2Data),
        .dbgData_o (dbgRegData)
    );

    always_comb begin
        case (srcBSel)
            srcBImmI: srcB = immI;
            srcBImmS: srcB = immS;
            default:  srcB = rs2Data;
        endcase
    end

    srAlu alu (
        .srcA_i   (rs1Data),
        .srcB_i   (srcB),
        .op_i     (aluOp),
        .result_o (aluResult),
        .zero_o   (aluZero)
    );

    always_comb begin
        case (wdSel)
            wdImmU:  wdata = immU;
            wdMem:   wdata = mem.rdata;
            default: wdata = aluResult;
        endcase
    end

    assign mem.addr      = aluResult[15:0];
    assign mem.wdata     = rs2Data;
    assign mem.respReady = 1'b1;

    // debug address 0 gives the pc
    assign dbgData_o = (dbgAddr_i != 5'd0) ? dbgRegData : pc;

endmodule

`default_nettype wire

// File: srDataMem.sv
// word-addressed data memory, one request at a time,
// response after DMEM_LATENCY cycles (1 to 7)
`timescale 1ns/1ps
`default_nettype none

module srDataMem #(
    parameter int DMEM_DEPTH   = 64,
    parameter int DMEM_LATENCY = 2
) (
    input  logic clk,
    input  logic rst_n,
    srMemIf.mem  bus
);
    localparam int ADDR_W = $clog2(DMEM_DEPTH);

    logic [31:0] ram [DMEM_DEPTH];
    logic        busy;
    logic [2:0]  latCnt;
    logic        accept;
    logic [13:0] reqWord;
    logic [13:0] wordQ;

    // byte offset ignored, word accesses only
    assign reqWord = bus.addr[15:2];
    assign accept  = bus.reqValid && !busy;

    assign bus.reqReady  = !busy;
    assign bus.respValid = busy && (latCnt == 3'd0);
    assign bus.rdata     = (wordQ < 14'(DMEM_DEPTH)) ? ram[wordQ[ADDR_W-1:0]] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            latCnt <= '0;
        end else if (accept) begin
            busy   <= 1'b1;
            latCnt <= 3'(DMEM_LATENCY - 1);
        end else if (bus.respValid && bus.respReady) begin
            busy <= 1'b0;
        end else if (latCnt != 3'd0) begin
            latCnt <= latCnt - 3'd1;
        end
    end

    // address capture, store lands at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            wordQ <= reqWord;
        end
        if (accept && bus.wr && (reqWord < 14'(DMEM_DEPTH))) begin
            ram[reqWord[ADDR_W-1:0]] <= bus.wdata;
        end
    end

endmodule

`default_nettype wire

// File: srInstrMem.sv
// instruction memory, synchronous load port and combinational word read
`timescale 1ns/1ps
`default_nettype none

module srInstrMem import srPkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] waddr_i,
    input  logic [31:0]                   wdata_i,
    input  logic [29:0]                   raddr_i,
    output instrWord_t                    rdata_o
);
    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    logic [31:0] words [IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            words[waddr_i] <= wdata_i;
        end
    end

    // beyond the end reads as zero, which decodes as a no-op
    assign rdata_o = (raddr_i < 30'(IMEM_DEPTH)) ? words[raddr_i[ADDR_W-1:0]] : '0;

endmodule

`default_nettype wire

// File: srMemIf.sv
// data memory request/response bus between core and data memory
`timescale 1ns/1ps
`default_nettype none

interface srMemIf;
    logic        wr;
    logic [15:0] addr;
    logic        reqValid;
    logic        reqReady;
    logic        respValid;
    logic        respReady;
    logic [31:0] wdata;
    logic [31:0] rdata;

    modport cpu (
        output wr, addr, reqValid, respReady, wdata,
        input  reqReady, respValid, rdata
    );

    modport mem (
        input  wr, addr, reqValid, respReady, wdata,
        output reqReady, respValid, rdata
    );
endinterface

`default_nettype wire

// File: srPkg.sv
// opcode, funct3 and funct7 constants for the supported RV32I subset
// ALU operation and mux select enums, instruction word union
`default_nettype none

package srPkg;

    // major opcodes
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // funct3
    localparam logic [2:0] f3Add  = 3'b000;
    localparam logic [2:0] f3Sub  = 3'b000;
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3Srl  = 3'b101;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Addi = 3'b000;
    localparam logic [2:0] f3Lw   = 3'b010;
    localparam logic [2:0] f3Sw   = 3'b010;
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;

    // funct7, only sub differs
    localparam logic [6:0] f7Add  = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;
    localparam logic [6:0] f7Or   = 7'b0000000;
    localparam logic [6:0] f7Srl  = 7'b0000000;
    localparam logic [6:0] f7Sltu = 7'b0000000;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluSrl,
        aluSltu
    } aluOp_t;

    typedef enum logic [1:0] {
        srcBReg,
        srcBImmI,
        srcBImmS
    } srcBSel_t;

    typedef enum logic [1:0] {
        wdAlu,
        wdImmU,
        wdMem
    } wdSel_t;

    // same 32 bits, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sbType;
    } instrWord_t;

endpackage

`default_nettype wire

// File: srRegFile.sv
// 32 x 32 register file, two operand reads and a debug read
`timescale 1ns/1ps
`default_nettype none

module srRegFile (
    input  logic        clk,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    input  logic [4:0]  dbgAddr_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic        we_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    output logic [31:0] dbgData_o
);
    logic [31:0] regs [32];

    // x0 reads as zero whatever the array holds
    assign rdata1_o  = (raddr1_i != 5'd0) ? regs[raddr1_i] : '0;
    assign rdata2_o  = (raddr2_i != 5'd0) ? regs[raddr2_i] : '0;
    assign dbgData_o = (dbgAddr_i != 5'd0) ? regs[dbgAddr_i] : '0;

    always_ff @(posedge clk) begin
        if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: srSystem.sv
// top level: core, instruction memory and data memory
`timescale 1ns/1ps
`default_nettype none

module srSystem import srPkg::*; #(
    parameter int IMEM_DEPTH   = 64,
    parameter int DMEM_DEPTH   = 64,
    parameter int DMEM_LATENCY = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          runEn_i,
    input  logic                          imWe_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imWaddr_i,
    input  logic [31:0]                   imWdata_i,
    input  logic [4:0]                    regAddr_i,
    output logic [31:0]                   regData_o
);
    logic [29:0] imAddr;
    instrWord_t  imData;

    srMemIf memBus ();

    srCpu cpu (
        .clk       (clk),
        .rst_n     (rst_n),
        .runEn_i   (runEn_i),
        .imAddr_o  (imAddr),
        .imData_i  (imData),
        .dbgAddr_i (regAddr_i),
        .dbgData_o (regData_o),
        .mem       (memBus.cpu)
    );

    srInstrMem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) instrMem (
        .clk     (clk),
        .we_i    (imWe_i),
        .waddr_i (imWaddr_i),
        .wdata_i (imWdata_i),
        .raddr_i (imAddr),
        .rdata_o (imData)
    );

    srDataMem #(
        .DMEM_DEPTH   (DMEM_DEPTH),
        .DMEM_LATENCY (DMEM_LATENCY)
    ) dataMem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (memBus.mem)
    );

endmodule

`default_nettype wire

// File: srSystem_checker.sv
// concurrent assertions on the core's data memory handshake and reset state
// bound into every srCpu instance
`timescale 1ns/1ps
`default_nettype none

module srSystem_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        runEn_i,
    input logic        reqValid_i,
    input logic        reqReady_i,
    input logic        respValid_i,
    input logic [31:0] pc_i
);
    logic accept;
    logic pending;
    int   assertFails = 0;

    assign accept = reqValid_i && reqReady_i;

    // request accepted and response not yet seen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (respValid_i) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end
    end

    noReqWhileHeld: assert property (@(posedge clk) disable iff (!rst_n)
        !runEn_i |-> !reqValid_i)
        else begin
            $error("reqValid high while runEn_i is low");
            assertFails++;
        end

    singleRequest: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> !pending)
        else begin
            $error("second request accepted before respValid");
            assertFails++;
        end

    // pc frozen from acceptance up to the response edge
    pcHeld: assert property (@(posedge clk) disable iff (!rst_n)
        (accept || pending) && !respValid_i |=> $stable(pc_i))
        else begin
            $error("pc changed while a memory request was outstanding");
            assertFails++;
        end

    resetState: assert property (@(posedge clk)
        !rst_n ##1 !rst_n |-> (pc_i == 32'd0) && !reqValid_i && !respValid_i && reqReady_i)
        else begin
            $error("core or memory handshake not in reset state");
            assertFails++;
        end

endmodule

bind srCpu srSystem_checker memChecker (
    .clk         (clk),
    .rst_n       (rst_n),
    .runEn_i     (runEn_i),
    .reqValid_i  (mem.reqValid),
    .reqReady_i  (mem.reqReady),
    .respValid_i (mem.respValid),
    .pc_i        (pc)
);

`default_nettype wire

// File: srSystem_tb.sv
// system testbench with program table, instruction loader, run loop
// and register checks through the debug port
`timescale 1ns/1ps
`default_nettype none

module srSystem_tb;
    localparam int IMEM_DEPTH      = 64;
    localparam int DMEM_DEPTH      = 64;
    localparam int DMEM_LATENCY    = 3;
    localparam int IM_AW           = $clog2(IMEM_DEPTH);
    localparam int CLK_PERIOD      = 4;
    localparam int NUM_PROGS       = 4;
    localparam int MAX_WORDS       = 16;
    localparam int MAX_CHECKS      = 6;
    localparam int CYCLES_PER_PROG = 400;

    // {funct7, funct3} of the register ops
    localparam logic [9:0] fnAdd  = {7'h00, 3'b000};
    localparam logic [9:0] fnSub  = {7'h20, 3'b000};
    localparam logic [9:0] fnOr   = {7'h00, 3'b110};
    localparam logic [9:0] fnSrl  = {7'h00, 3'b101};
    localparam logic [9:0] fnSltu = {7'h00, 3'b011};
    localparam logic [2:0] fnBeq  = 3'b000;
    localparam logic [2:0] fnBne  = 3'b001;

    logic             clk;
    logic             rst_n;
    logic             runEn;
    logic             imWe;
    logic [IM_AW-1:0] imWaddr;
    logic [31:0]      imWdata;
    logic [4:0]       regAddr;
    logic [31:0]      regData;

    logic [31:0] progWords [NUM_PROGS][MAX_WORDS];
    int          progLen [NUM_PROGS];
    logic [31:0] haltPc [NUM_PROGS];
    logic [4:0]  chkReg [NUM_PROGS][MAX_CHECKS];
    logic [31:0] chkVal [NUM_PROGS][MAX_CHECKS];
    int          chkCount [NUM_PROGS];
    string       progName [NUM_PROGS];

    integer seed;
    int     curProg;
    int     errorCount;
    int     passCount;
    int     failCount;
    int     assertErrors;

    srSystem #(
        .IMEM_DEPTH   (IMEM_DEPTH),
        .DMEM_DEPTH   (DMEM_DEPTH),
        .DMEM_LATENCY (DMEM_LATENCY)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .runEn_i   (runEn),
        .imWe_i    (imWe),
        .imWaddr_i (imWaddr),
        .imWdata_i (imWdata),
        .regAddr_i (regAddr),
        .regData_o (regData)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // RV32I encodings
    function automatic logic [31:0] rOp(input logic [9:0] fn, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchOp(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic newProgram(input int p, input string name);
        curProg     = p;
        progName[p] = name;
        progLen[p]  = 0;
        chkCount[p] = 0;
    endtask

    task automatic emit(input logic [31:0] w);
        progWords[curProg][progLen[curProg]] = w;
        progLen[curProg]++;
    endtask

    task automatic expectReg(input logic [4:0] r, input logic [31:0] v);
        chkReg[curProg][chkCount[curProg]] = r;
        chkVal[curProg][chkCount[curProg]] = v;
        chkCount[curProg]++;
    endtask

    // beq x0,x0,0 self-loop
    task automatic halt();
        haltPc[curProg] = 32'(4 * progLen[curProg]);
        emit(branchOp(fnBeq, 5'd0, 5'd0, 13'd0));
    endtask

    // lui then addi with the upper part rounded for the sign of the low 12 bits
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] rounded;
        rounded = v + 32'h800;
        emit(lui(rd, rounded[31:12]));
        emit(addi(rd, rd, v[11:0]));
    endtask

    task automatic buildTable();
        logic [31:0] patA;
        logic [31:0] patB;

        newProgram(0, "arith");
        emit(addi(5'd1, 5'd0, 12'd100));
        emit(addi(5'd2, 5'd0, 12'd37));
        emit(rOp(fnAdd, 5'd3, 5'd1, 5'd2));
        emit(rOp(fnSub, 5'd4, 5'd1, 5'd2));
        emit(rOp(fnOr, 5'd5, 5'd1, 5'd2));
        emit(lui(5'd6, 20'h80000));
        // shift amount 37 uses only its low 5 bits
        emit(rOp(fnSrl, 5'd7, 5'd6, 5'd2));
        emit(rOp(fnSltu, 5'd8, 5'd2, 5'd1));
        halt();
        expectReg(5'd3, 32'd137);
        expectReg(5'd4, 32'd63);
        expectReg(5'd5, 32'h0000_0065);
        expectReg(5'd6, 32'h8000_0000);
        expectReg(5'd7, 32'h0400_0000);
        expectReg(5'd8, 32'd1);

        newProgram(1, "immediates");
        // addi x1, x0, -5
        emit(addi(5'd1, 5'd0, 12'hFFB));
        emit(lui(5'd2, 20'hABCDE));
        emit(addi(5'd2, 5'd2, 12'h123));
        emit(addi(5'd0, 5'd0, 12'd55));
        emit(rOp(fnSltu, 5'd3, 5'd0, 5'd1));
        emit(rOp(fnAdd, 5'd4, 5'd0, 5'd0));
        emit(rOp(fnSub, 5'd5, 5'd0, 5'd1));
        halt();
        expectReg(5'd1, 32'hFFFF_FFFB);
        expectReg(5'd2, 32'hABCD_E123);
        expectReg(5'd3, 32'd1);
        expectReg(5'd4, 32'd0);
        expectReg(5'd5, 32'd5);

        newProgram(2, "branches");
        emit(addi(5'd1, 5'd0, 12'd7));
        emit(addi(5'd2, 5'd0, 12'd7));
        emit(addi(5'd3, 5'd0, 12'd9));
        emit(addi(5'd5, 5'd0, 12'd9));
        // taken so the next addi is skipped
        emit(branchOp(fnBeq, 5'd1, 5'd2, 13'd8));
        emit(addi(5'd3, 5'd0, 12'd1));
        emit(branchOp(fnBne, 5'd1, 5'd2, 13'd8));
        emit(addi(5'd4, 5'd0, 12'd2));
        // taken so the next addi is skipped
        emit(branchOp(fnBne, 5'd1, 5'd0, 13'd8));
        emit(addi(5'd5, 5'd0, 12'd3));
        emit(branchOp(fnBeq, 5'd1, 5'd0, 13'd8));
        emit(addi(5'd6, 5'd0, 12'd4));
        halt();
        expectReg(5'd1, 32'd7);
        expectReg(5'd2, 32'd7);
        expectReg(5'd3, 32'd9);
        expectReg(5'd4, 32'd2);
        expectReg(5'd5, 32'd9);
        expectReg(5'd6, 32'd4);

        patA = $random(seed);
        patB = $random(seed);
        newProgram(3, "memory");
        // store at pc 0 sits decoded while runEn is low during the load
        emit(sw(5'd0, 5'd0, 12'h048));
        loadConst(5'd1, patA);
        loadConst(5'd2, patB);
        emit(addi(5'd10, 5'd0, 12'h040));
        emit(sw(5'd1, 5'd10, 12'd0));
        emit(sw(5'd2, 5'd10, 12'd4));
        emit(lw(5'd3, 5'd10, 12'd0));
        emit(lw(5'd4, 5'd10, 12'd4));
        emit(sw(5'd4, 5'd10, 12'd8));
        emit(lw(5'd5, 5'd10, 12'd8));
        emit(rOp(fnAdd, 5'd6, 5'd3, 5'd4));
        halt();
        expectReg(5'd1, patA);
        expectReg(5'd2, patB);
        expectReg(5'd3, patA);
        expectReg(5'd4, patB);
        expectReg(5'd5, patB);
        expectReg(5'd6, patA + patB);
    endtask

    task automatic resetDut();
        @(posedge clk);
        runEn <= 1'b0;
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic loadProgram(input int p);
        int i;
        for (i = 0; i < progLen[p]; i++) begin
            @(posedge clk);
            imWe    <= 1'b1;
            imWaddr <= IM_AW'(i);
            imWdata <= progWords[p][i];
        end
        @(posedge clk);
        imWe <= 1'b0;
    endtask

    task automatic runProgram(input int p);
        int i;
        int mismatches;
        mismatches = 0;
        curProg    = p;
        resetDut();
        loadProgram(p);
        @(posedge clk);
        runEn   <= 1'b1;
        regAddr <= 5'd0;
        // debug address 0 reads the pc
        @(negedge clk);
        while (regData !== haltPc[p]) begin
            @(negedge clk);
        end
        for (i = 0; i < chkCount[p]; i++) begin
            @(posedge clk);
            regAddr <= chkReg[p][i];
            @(negedge clk);
            if (regData !== chkVal[p][i]) begin
                $display("FAIL t=%0t x%0d got %h expected %h",
                         $time, chkReg[p][i], regData, chkVal[p][i]);
                mismatches++;
            end
        end
        errorCount += mismatches;
        if (mismatches == 0) begin
            passCount++;
            $display("test %0d %s: passed", p, progName[p]);
        end else begin
            failCount++;
            $display("test %0d %s: %0d register mismatches", p, progName[p], mismatches);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        runEn        = 1'b0;
        imWe         = 1'b0;
        imWaddr      = '0;
        imWdata      = '0;
        regAddr      = '0;
        seed         = 80984;
        errorCount   = 0;
        passCount    = 0;
        failCount    = 0;
        assertErrors = 0;
        buildTable();
        for (int p = 0; p < NUM_PROGS; p++) begin
            runProgram(p);
        end
        assertErrors = dut.cpu.memChecker.assertFails;
        $display("%0d tests, %0d passed, %0d failed, %0d mismatches, %0d assertion errors",
                 NUM_PROGS, passCount, failCount, errorCount, assertErrors);
        if (errorCount == 0 && assertErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (NUM_PROGS * CYCLES_PER_PROG) @(posedge clk);
        $display("watchdog expired: test %0d (%s) never reached its halt address",
                 curProg, progName[curProg]);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
srPkg.sv
srMemIf.sv
srInstrMem.sv
srDataMem.sv
srRegFile.sv
srAlu.sv
srControl.sv
srCpu.sv
srSystem.sv
srSystem_checker.sv
srSystem_tb.sv
